/* compile.f */
monitor_pkg.sv
link_pkg.sv
monitor_readback.sv
monitor_event_count.sv
monitor_frame_tx.sv
uart_byte_tx.sv
monitor_link.sv
tb_monitor_link.sv

/* link_pkg.sv */
`default_nettype none

package link_pkg;

	localparam int CLKS_PER_BIT = 8; // Clock cycles per serial bit.
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT + 1);

	localparam int BYTE_W = 8;
	localparam int BIT_IDX_W = $clog2(BYTE_W);

	// Set in header and trailer bytes, clear in data bytes.
	localparam logic [BYTE_W-1:0] MARK_BIT = 8'h80;

	typedef enum logic [2:0] {
		FRAME_IDLE,
		FRAME_HEADER,
		FRAME_READBACK,
		FRAME_EVENTS,
		FRAME_TRAILER
	} frame_state_t;

	typedef enum logic [1:0] {
		LINE_IDLE,
		LINE_START,
		LINE_DATA,
		LINE_STOP
	} line_state_t;

endpackage

`default_nettype wire

/* monitor_cases.txt */
# name rb0..rb14 (15 readback values) pulses0..pulses3 counts0..counts3 checksum
# Decimal values. Counts saturate at 127, checksum is the sum of the 19 data words mod 128.
zeros 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
ramp 1 2 3 4 5 6 7 8 9 10 11 12 13 14 15 1 2 3 4 1 2 3 4 2
all_ones 127 127 127 127 127 127 127 127 127 127 127 127 127 127 127 0 0 0 0 0 0 0 0 113
saturate 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 140 127 128 3 127 127 127 3 22
mixed 100 27 64 3 99 18 7 120 55 42 11 0 88 77 66 9 0 31 16 9 0 31 16 65
alternate 85 42 85 42 85 42 85 42 85 42 85 42 85 42 85 50 60 70 80 50 60 70 80 82

/* monitor_event_count.sv */
`default_nettype none

module monitor_event_count
	import monitor_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire tx_en,
	input wire tx_data_loaded,
	input wire [N_EVENTS-1:0] event_pulse,
	output logic tx_data_ready,
	output logic [WORD_W-1:0] tx_data,
	output logic tx_complete
);

	logic [N_EVENTS-1:0][WORD_W-1:0] counts;
	logic [N_EVENTS-1:0][WORD_W-1:0] snapshot;
	logic [EV_CNT_W-1:0] tx_cnt;
	logic tx_en_q;
	logic snap;
	logic loaded_s1;
	logic loaded_s2;

	assign snap = tx_en && !tx_en_q; // First cycle of a send window.

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_en_q <= 1'b0;
			counts <= '0;
		end else begin
			tx_en_q <= tx_en;
			for (int i = 0; i < N_EVENTS; i++) begin
				if (snap) begin
					counts[i] <= WORD_W'(event_pulse[i]); // This pulse opens the new window.
				end else if (event_pulse[i] && counts[i] != COUNT_MAX) begin
					counts[i] <= counts[i] + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (snap) begin
			snapshot <= counts;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			loaded_s1 <= 1'b0;
			loaded_s2 <= 1'b0;
		end else begin
			loaded_s1 <= tx_data_loaded;
			loaded_s2 <= loaded_s1;
		end
	end

	// Same word exchange as the readback source.
	always_ff @(posedge clk) begin
		if (rst || !tx_en) begin
			tx_cnt <= '0;
			tx_data_ready <= 1'b0;
			tx_complete <= 1'b0;
		end else if (!tx_complete) begin
			if (!tx_data_ready && !loaded_s2) begin
				if (tx_cnt == EV_CNT_W'(N_EVENTS)) begin
					tx_complete <= 1'b1;
				end else begin
					tx_data_ready <= 1'b1;
				end
			end else if (tx_data_ready && loaded_s2) begin
				tx_data_ready <= 1'b0;
				tx_cnt <= tx_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		tx_data = '0;
		for (int i = 0; i < N_EVENTS; i++) begin
			if (tx_cnt == EV_CNT_W'(i)) begin
				tx_data = snapshot[i];
			end
		end
	end

endmodule

`default_nettype wire

/* monitor_frame_tx.sv */
`default_nettype none

module monitor_frame_tx
	import monitor_pkg::*;
	import link_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire frame_req,
	input wire rb_tx_data_ready,
	input wire rb_tx_complete,
	input wire [WORD_W-1:0] rb_tx_data,
	input wire ev_tx_data_ready,
	input wire ev_tx_complete,
	input wire [WORD_W-1:0] ev_tx_data,
	input wire byte_busy,
	output logic rb_tx_en,
	output logic rb_tx_data_loaded,
	output logic ev_tx_en,
	output logic ev_tx_data_loaded,
	output logic [BYTE_W-1:0] byte_data,
	output logic byte_start,
	output logic frame_busy
);

	frame_state_t state;
	logic [WORD_W-1:0] seq_num;
	logic [WORD_W-1:0] checksum;
	logic trailer_sent;
	logic line_free;
	logic frame_done;
	logic accept_req;
	logic in_events;
	logic src_ready;
	logic src_loaded;
	logic src_complete;
	logic [WORD_W-1:0] src_data;

	// The serializer raises byte_busy one cycle after byte_start.
	assign line_free = !byte_busy && !byte_start;

	assign frame_done = (state == FRAME_TRAILER) && trailer_sent && line_free;
	assign frame_busy = (state != FRAME_IDLE) && !frame_done;
	assign accept_req = frame_req && !frame_busy;

	// Both word phases run the same exchange on the active source.
	assign in_events = (state == FRAME_EVENTS);
	assign src_ready = in_events ? ev_tx_data_ready : rb_tx_data_ready;
	assign src_loaded = in_events ? ev_tx_data_loaded : rb_tx_data_loaded;
	assign src_complete = in_events ? ev_tx_complete : rb_tx_complete;
	assign src_data = in_events ? ev_tx_data : rb_tx_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FRAME_IDLE;
			seq_num <= '0;
			checksum <= '0;
			trailer_sent <= 1'b0;
			rb_tx_en <= 1'b0;
			rb_tx_data_loaded <= 1'b0;
			ev_tx_en <= 1'b0;
			ev_tx_data_loaded <= 1'b0;
			byte_start <= 1'b0;
		end else begin
			byte_start <= 1'b0;
			case (state)
				FRAME_IDLE: begin
					if (accept_req) begin
						state <= FRAME_HEADER;
					end
				end
				FRAME_HEADER: begin
					if (line_free) begin
						byte_data <= MARK_BIT | BYTE_W'(seq_num);
						byte_start <= 1'b1;
						checksum <= '0;
						rb_tx_en <= 1'b1;
						state <= FRAME_READBACK;
					end
				end
				FRAME_READBACK, FRAME_EVENTS: begin
					if (src_complete) begin
						rb_tx_en <= 1'b0;
						ev_tx_en <= !in_events; // Readbacks done, start the counts.
						state <= in_events ? FRAME_TRAILER : FRAME_EVENTS;
					end else if (src_loaded) begin
						if (!src_ready) begin
							rb_tx_data_loaded <= 1'b0;
							ev_tx_data_loaded <= 1'b0;
						end
					end else if (src_ready && line_free) begin
						byte_data <= BYTE_W'(src_data);
						byte_start <= 1'b1;
						checksum <= checksum + src_data;
						rb_tx_data_loaded <= !in_events;
						ev_tx_data_loaded <= in_events;
					end
				end
				FRAME_TRAILER: begin
					if (!trailer_sent) begin
						if (line_free) begin
							byte_data <= MARK_BIT | BYTE_W'(checksum);
							byte_start <= 1'b1;
							seq_num <= seq_num + 1'b1; // wraps at 128
							trailer_sent <= 1'b1;
						end
					end else if (line_free) begin
						trailer_sent <= 1'b0;
						state <= accept_req ? FRAME_HEADER : FRAME_IDLE;
					end
				end
				default: state <= FRAME_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* monitor_link.sv */
`default_nettype none

module monitor_link
	import monitor_pkg::*;
	import link_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire frame_req,
	input wire [N_READBACKS-1:0][WORD_W-1:0] rb,
	input wire [N_EVENTS-1:0] event_pulse,
	output logic tx_line,
	output logic frame_busy
);

	logic rb_tx_en;
	logic rb_tx_data_loaded;
	logic rb_tx_data_ready;
	logic rb_tx_complete;
	logic [WORD_W-1:0] rb_tx_data;
	logic ev_tx_en;
	logic ev_tx_data_loaded;
	logic ev_tx_data_ready;
	logic ev_tx_complete;
	logic [WORD_W-1:0] ev_tx_data;
	logic [BYTE_W-1:0] byte_data;
	logic byte_start;
	logic byte_busy;

	monitor_readback readback_i (
		.clk(clk),
		.rst(rst),
		.tx_en(rb_tx_en),
		.tx_data_loaded(rb_tx_data_loaded),
		.rb(rb),
		.tx_data_ready(rb_tx_data_ready),
		.tx_data(rb_tx_data),
		.tx_complete(rb_tx_complete)
	);

	monitor_event_count event_count_i (
		.clk(clk),
		.rst(rst),
		.tx_en(ev_tx_en),
		.tx_data_loaded(ev_tx_data_loaded),
		.event_pulse(event_pulse),
		.tx_data_ready(ev_tx_data_ready),
		.tx_data(ev_tx_data),
		.tx_complete(ev_tx_complete)
	);

	monitor_frame_tx frame_tx_i (
		.clk(clk),
		.rst(rst),
		.frame_req(frame_req),
		.rb_tx_data_ready(rb_tx_data_ready),
		.rb_tx_complete(rb_tx_complete),
		.rb_tx_data(rb_tx_data),
		.ev_tx_data_ready(ev_tx_data_ready),
		.ev_tx_complete(ev_tx_complete),
		.ev_tx_data(ev_tx_data),
		.byte_busy(byte_busy),
		.rb_tx_en(rb_tx_en),
		.rb_tx_data_loaded(rb_tx_data_loaded),
		.ev_tx_en(ev_tx_en),
		.ev_tx_data_loaded(ev_tx_data_loaded),
		.byte_data(byte_data),
		.byte_start(byte_start),
		.frame_busy(frame_busy)
	);

	uart_byte_tx byte_tx_i (
		.clk(clk),
		.rst(rst),
		.byte_start(byte_start),
		.byte_data(byte_data),
		.byte_busy(byte_busy),
		.tx_line(tx_line)
	);

endmodule

`default_nettype wire

/* monitor_pkg.sv */
`default_nettype none

package monitor_pkg;

	// Every monitored value fits in one word of this width.
	localparam int WORD_W = 7;

	localparam int N_READBACKS = 15; // Readback words per frame.
	localparam int N_EVENTS = 4; // Event inputs, one count word each.

	// Largest count a word can carry. Counters stop here.
	localparam logic [WORD_W-1:0] COUNT_MAX = 7'd127;

	// Index widths also hold the value one past the last word.
	localparam int RB_CNT_W = $clog2(N_READBACKS + 1);
	localparam int EV_CNT_W = $clog2(N_EVENTS + 1);

endpackage

`default_nettype wire

/* monitor_readback.sv */
`default_nettype none

module monitor_readback
	import monitor_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire tx_en,
	input wire tx_data_loaded,
	input wire [N_READBACKS-1:0][WORD_W-1:0] rb,
	output logic tx_data_ready,
	output logic [WORD_W-1:0] tx_data,
	output logic tx_complete
);

	logic [N_READBACKS-1:0][WORD_W-1:0] stage_a;
	logic [N_READBACKS-1:0][WORD_W-1:0] stage_b;
	logic [RB_CNT_W-1:0] tx_cnt;
	logic loaded_s1;
	logic loaded_s2;
	logic last_sent;

	// The readbacks are retimed twice before they are sent.
	always_ff @(posedge clk) begin
		stage_a <= rb;
		stage_b <= stage_a;
	end

	assign last_sent = (tx_cnt == RB_CNT_W'(N_READBACKS));

	always_ff @(posedge clk) begin
		if (rst) begin
			loaded_s1 <= 1'b0;
			loaded_s2 <= 1'b0;
		end else begin
			loaded_s1 <= tx_data_loaded; // The framer may sit in another clock domain.
			loaded_s2 <= loaded_s1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_cnt <= '0;
			tx_data_ready <= 1'b0;
			tx_complete <= 1'b0;
		end else if (!tx_en) begin
			tx_cnt <= '0;
			tx_data_ready <= 1'b0;
			tx_complete <= 1'b0;
		end else if (!tx_complete) begin
			if (!tx_data_ready && !loaded_s2) begin
				if (last_sent) begin
					tx_complete <= 1'b1;
				end else begin
					tx_data_ready <= 1'b1;
				end
			end else if (tx_data_ready && loaded_s2) begin
				tx_data_ready <= 1'b0; // Word taken, move to the next one.
				tx_cnt <= tx_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		tx_data = '0;
		for (int i = 0; i < N_READBACKS; i++) begin
			if (tx_cnt == RB_CNT_W'(i)) begin
				tx_data = stage_b[i];
			end
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the monitor link testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f compile.f --top-module tb_monitor_link -o tb_monitor_link

./obj_dir/tb_monitor_link > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0

/* tb_monitor_link.sv */
`default_nettype none

module tb_monitor_link
	import monitor_pkg::*;
	import link_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_CASES = 16;
	localparam int FRAME_BYTES = N_READBACKS + N_EVENTS + 2;

	logic clk;
	logic rst;
	logic frame_req;
	logic [N_READBACKS-1:0][WORD_W-1:0] rb;
	logic [N_EVENTS-1:0] event_pulse;
	wire tx_line;
	wire frame_busy;

	string case_name [MAX_CASES];
	int case_rb [MAX_CASES][N_READBACKS];
	int case_pulses [MAX_CASES][N_EVENTS];
	int case_counts [MAX_CASES][N_EVENTS];
	int case_sum [MAX_CASES];
	int n_cases;
	logic [BYTE_W-1:0] rx_bytes [32];
	int n_rx;
	int value_errors = 0;
	int other_errors = 0;
	int cycles = 0;
	int cycle_limit = 100;
	logic [31:0] lcg_state = 32'd65326;

	monitor_link monitor_link_i (
		.clk(clk),
		.rst(rst),
		.frame_req(frame_req),
		.rb(rb),
		.event_pulse(event_pulse),
		.tx_line(tx_line),
		.frame_busy(frame_busy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: frame traffic still running after %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic void check_line_idle();
		if (tx_line !== 1'b1 || frame_busy !== 1'b0) begin
			$display("Line not idle outside a frame: tx_line=%b frame_busy=%b",
				tx_line, frame_busy);
			other_errors++;
		end
	endfunction

	function automatic void check_byte(input string name, input string field, input int idx,
			input logic [BYTE_W-1:0] expected, input logic [BYTE_W-1:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s %s byte %0d: expected 0x%02h, actual 0x%02h",
				name, field, idx, expected, actual);
			value_errors++;
		end
	endfunction

	task automatic read_cases();
		int fd;
		int got;
		string tok;
		string rest;
		n_cases = 0;
		fd = $fopen("monitor_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open monitor_cases.txt");
			other_errors++;
		end else begin
			while (n_cases < MAX_CASES && $fscanf(fd, "%s", tok) == 1) begin
				if (tok.substr(0, 0) == "#") begin
					got = $fgets(rest, fd); // Skip the rest of a comment line.
				end else begin
					case_name[n_cases] = tok;
					got = 0;
					for (int i = 0; i < N_READBACKS; i++) begin
						got += $fscanf(fd, "%d", case_rb[n_cases][i]);
					end
					for (int i = 0; i < N_EVENTS; i++) begin
						got += $fscanf(fd, "%d", case_pulses[n_cases][i]);
					end
					for (int i = 0; i < N_EVENTS; i++) begin
						got += $fscanf(fd, "%d", case_counts[n_cases][i]);
					end
					got += $fscanf(fd, "%d", case_sum[n_cases]);
					if (got != N_READBACKS + 2 * N_EVENTS + 1) begin
						$display("Case %s has missing fields in the cases file", tok);
						other_errors++;
					end
					n_cases++;
				end
			end
			$fclose(fd);
		end
		if (n_cases == 0) begin
			$display("No cases were read");
			other_errors++;
		end
	endtask

	task automatic check_idle(input int n);
		repeat (n) begin
			@(negedge clk);
			check_line_idle();
		end
	endtask

	task automatic issue_pulses(input int c);
		int left [N_EVENTS];
		logic [31:0] r;
		bit more;
		for (int i = 0; i < N_EVENTS; i++) begin
			left[i] = case_pulses[c][i];
		end
		do begin
			@(negedge clk);
			check_line_idle();
			r = lcg_next();
			more = 1'b0;
			for (int i = 0; i < N_EVENTS; i++) begin
				event_pulse[i] = (left[i] > 0) && (r[16 + 3 * i +: 3] != 3'd0); // Random gaps.
				if (event_pulse[i]) begin
					left[i]--;
				end
				more = more || (left[i] > 0);
			end
		end while (more);
		@(negedge clk);
		event_pulse = '0;
	endtask

	// Serial decoder. Samples each bit near its middle.
	task automatic receive_frame();
		logic [BYTE_W-1:0] data;
		bit done;
		n_rx = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (tx_line === 1'b0) begin
				repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
				if (tx_line !== 1'b0) begin
					$display("Start bit of byte %0d did not stay low", n_rx);
					other_errors++;
				end
				for (int k = 0; k < BYTE_W; k++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					data[k] = tx_line;
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				if (tx_line !== 1'b1) begin
					$display("Stop bit of byte %0d was not high", n_rx);
					other_errors++;
				end
				if (n_rx < 32) begin
					rx_bytes[n_rx] = data;
				end
				n_rx++;
			end else if (frame_busy === 1'b0) begin
				done = 1'b1;
			end
		end
	endtask

	task automatic run_case(input int c, input int seq);
		int sum;
		int exp_count;
		check_idle(4);
		for (int i = 0; i < N_READBACKS; i++) begin
			rb[i] = WORD_W'(case_rb[c][i]);
		end
		issue_pulses(c);
		frame_req = 1'b1;
		@(negedge clk);
		frame_req = 1'b0;
		fork
			receive_frame();
			begin
				repeat (200) @(negedge clk); // Mid-frame request that must be ignored.
				frame_req = 1'b1;
				@(negedge clk);
				frame_req = 1'b0;
			end
		join
		if (n_rx != FRAME_BYTES) begin
			$display("Case %s: received %0d bytes instead of %0d", case_name[c], n_rx, FRAME_BYTES);
			other_errors++;
		end else begin
			check_byte(case_name[c], "header", 0, MARK_BIT | BYTE_W'(seq), rx_bytes[0]);
			sum = 0;
			for (int i = 0; i < N_READBACKS; i++) begin
				check_byte(case_name[c], "readback", 1 + i, {1'b0, rb[i]}, rx_bytes[1 + i]);
				sum += int'(rb[i]);
			end
			for (int i = 0; i < N_EVENTS; i++) begin
				exp_count = (case_pulses[c][i] > 127) ? 127 : case_pulses[c][i];
				if (exp_count != case_counts[c][i]) begin
					$display("Case %s: file count %0d does not match %0d pulses",
						case_name[c], case_counts[c][i], case_pulses[c][i]);
					other_errors++;
				end
				check_byte(case_name[c], "count", 16 + i, BYTE_W'(exp_count), rx_bytes[16 + i]);
				sum += exp_count;
			end
			if (sum % 128 != case_sum[c]) begin
				$display("Case %s: file checksum %0d does not match the data", case_name[c],
					case_sum[c]);
				other_errors++;
			end
			check_byte(case_name[c], "trailer", FRAME_BYTES - 1, MARK_BIT | BYTE_W'(sum % 128),
				rx_bytes[FRAME_BYTES - 1]);
		end
	endtask

	initial begin
		rst = 1'b1;
		frame_req = 1'b0;
		rb = '0;
		event_pulse = '0;
		read_cases();
		cycle_limit = n_cases * (FRAME_BYTES * 10 * CLKS_PER_BIT + 400) + 100;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_idle(16);
		for (int c = 0; c < n_cases; c++) begin
			run_case(c, c % 128);
		end
		check_idle(4 * CLKS_PER_BIT); // No frame may follow the last ignored request.
		$display("Errors: %0d wrong values, %0d link or framing errors", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* uart_byte_tx.sv */
`default_nettype none

module uart_byte_tx
	import link_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire byte_start,
	input wire [BYTE_W-1:0] byte_data,
	output logic byte_busy,
	output logic tx_line
);

	line_state_t state;
	logic [BIT_CNT_W-1:0] clk_cnt;
	logic [BIT_IDX_W-1:0] bit_idx;
	logic [BYTE_W-1:0] shift;
	logic bit_end;

	assign bit_end = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= LINE_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			byte_busy <= 1'b0;
			tx_line <= 1'b1; // Line idles high.
		end else begin
			clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
			case (state)
				LINE_IDLE: begin
					clk_cnt <= '0;
					if (byte_start) begin
						shift <= byte_data;
						tx_line <= 1'b0;
						byte_busy <= 1'b1;
						state <= LINE_START;
					end
				end
				LINE_START: begin
					if (bit_end) begin
						tx_line <= shift[0]; // LSB goes first.
						shift <= shift >> 1;
						bit_idx <= '0;
						state <= LINE_DATA;
					end
				end
				LINE_DATA: begin
					if (bit_end) begin
						if (bit_idx == BIT_IDX_W'(BYTE_W - 1)) begin
							tx_line <= 1'b1;
							state <= LINE_STOP;
						end else begin
							tx_line <= shift[0];
							shift <= shift >> 1;
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				LINE_STOP: begin
					if (bit_end) begin
						byte_busy <= 1'b0; // Busy covers the whole stop bit.
						state <= LINE_IDLE;
					end
				end
				default: state <= LINE_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire
